//--- src/mipsPkg.sv
// Encodings cover only the supported MIPS subset plus the all-ones halt opcode
package mipsPkg;
	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [2:0] aluCtrlT;
	typedef logic [1:0] branchT;

	// Primary opcodes
	localparam opcodeT opRType = 6'b000000;
	localparam opcodeT opAddi = 6'b001000;
	localparam opcodeT opLw = 6'b100011;
	localparam opcodeT opSw = 6'b101011;
	localparam opcodeT opBeq = 6'b000100;
	localparam opcodeT opBne = 6'b000101;
	localparam opcodeT opBgtz = 6'b000111;
	localparam opcodeT opHalt = 6'b111111;

	// R-type function codes
	localparam functT fnAdd = 6'b100000;
	localparam functT fnAddu = 6'b100001;
	localparam functT fnSub = 6'b100010;
	localparam functT fnSubu = 6'b100011;
	localparam functT fnAnd = 6'b100100;
	localparam functT fnOr = 6'b100101;
	localparam functT fnSll = 6'b000000;
	localparam functT fnSlt = 6'b101010;
	localparam functT fnSltu = 6'b101011;

	// ALU operations
	localparam aluCtrlT aluAnd = 3'd0;
	localparam aluCtrlT aluOr = 3'd1;
	localparam aluCtrlT aluAdd = 3'd2;
	localparam aluCtrlT aluSlt = 3'd3;
	localparam aluCtrlT aluAddu = 3'd4;
	localparam aluCtrlT aluSll = 3'd5;
	localparam aluCtrlT aluSub = 3'd6;
	localparam aluCtrlT aluSltu = 3'd7;

	// Branch kinds
	localparam branchT brNone = 2'd0;
	localparam branchT brEq = 2'd1;
	localparam branchT brNe = 2'd2;
	localparam branchT brGtz = 2'd3;
endpackage

//--- src/instDecoder.sv
// Unknown opcodes and functs decode as a no-op with all write enables low
`timescale 1ns/1ps

module instDecoder import mipsPkg::*; (
	input wordT inst,
	output logic regWr,
	output logic regDst,
	output logic aluSrc,
	output logic extOp,
	output logic memWr,
	output logic memToReg,
	output logic useShamt,
	output logic isHalt,
	output aluCtrlT aluCtrl,
	output branchT branch
);
	opcodeT op;
	functT fn;

	assign op = inst[31:26];
	assign fn = inst[5:0];

	always_comb begin
		regWr = 1'b0;
		regDst = 1'b0;
		aluSrc = 1'b0;
		extOp = 1'b0;
		memWr = 1'b0;
		memToReg = 1'b0;
		useShamt = 1'b0;
		isHalt = 1'b0;
		aluCtrl = aluAnd;
		branch = brNone;
		case (op)
			opRType: begin
				regWr = 1'b1;
				regDst = 1'b1;
				case (fn)
					fnAdd: aluCtrl = aluAdd;
					fnAddu: aluCtrl = aluAddu;
					fnSub: aluCtrl = aluSub;
					fnSubu: aluCtrl = aluSub;
					fnAnd: aluCtrl = aluAnd;
					fnOr: aluCtrl = aluOr;
					fnSlt: aluCtrl = aluSlt;
					fnSltu: aluCtrl = aluSltu;
					fnSll: begin
						aluCtrl = aluSll;
						useShamt = 1'b1;
					end
					default: begin
						regWr = 1'b0;
						regDst = 1'b0;
					end
				endcase
			end
			opAddi: begin
				regWr = 1'b1;
				aluSrc = 1'b1;
				extOp = 1'b1;
				aluCtrl = aluAdd;
			end
			opLw: begin
				regWr = 1'b1;
				aluSrc = 1'b1;
				extOp = 1'b1;
				memToReg = 1'b1;
				aluCtrl = aluAdd;
			end
			opSw: begin
				aluSrc = 1'b1;
				extOp = 1'b1;
				memWr = 1'b1;
				aluCtrl = aluAdd;
			end
			// Branches compare rs against rt through a subtract
			opBeq: begin
				extOp = 1'b1;
				aluCtrl = aluSub;
				branch = brEq;
			end
			opBne: begin
				extOp = 1'b1;
				aluCtrl = aluSub;
				branch = brNe;
			end
			opBgtz: begin
				extOp = 1'b1;
				aluCtrl = aluSub;
				branch = brGtz;
			end
			opHalt: isHalt = 1'b1;
			default: isHalt = 1'b0;
		endcase
	end
endmodule

//--- src/regFile.sv
// Register 0 is hardwired to zero and a same-cycle write is visible on the read ports
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
	input logic clk,
	input logic reset,
	input logic wrEn,
	input regIdxT wrIdx,
	input wordT wrData,
	input regIdxT rdIdxA,
	input regIdxT rdIdxB,
	output wordT rdDataA,
	output wordT rdDataB
);
	wordT regs [32];

	function automatic wordT readPort(input regIdxT idx);
		if (idx == '0) begin
			return '0;
		end else if (wrEn && wrIdx == idx) begin
			return wrData;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrIdx != '0) begin
			regs[wrIdx] <= wrData;
		end
	end

	always_comb begin
		rdDataA = readPort(rdIdxA);
		rdDataB = readPort(rdIdxB);
	end
endmodule

//--- src/alu.sv
// No overflow detection so signed and unsigned adds both wrap
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input aluCtrlT ctrl,
	input wordT a,
	input wordT b,
	input logic [4:0] shamt,
	output wordT result,
	output logic zero,
	output logic sign
);
	always_comb begin
		case (ctrl)
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluAdd: result = a + b;
			aluAddu: result = a + b;
			aluSub: result = a - b;
			aluSll: result = b << shamt;
			aluSlt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			aluSltu: begin
				result = {31'b0, a < b};
			end
			default: result = '0;
		endcase
	end

	// Flags feed branch resolution
	assign zero = (result == '0);
	assign sign = result[31];
endmodule

//--- src/memArbiter.sv
// Host always wins the port and may stall the core for as long as it keeps requesting
`timescale 1ns/1ps

module memArbiter import mipsPkg::*; #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic reset,
	input logic hostEn,
	input logic hostWe,
	input logic [$clog2(memWords)-1:0] hostAddr,
	input wordT hostWData,
	output wordT hostRData,
	input logic fetchEn,
	input wordT fetchAddr,
	output wordT fetchData,
	output logic fetchGrant,
	input logic dataEn,
	input logic dataWe,
	input wordT dataAddr,
	input wordT dataWData,
	output wordT dataRData,
	output logic dataGrant,
	output logic memEn,
	output logic memWe,
	output logic [$clog2(memWords)-1:0] memAddr,
	output wordT memWData,
	input wordT memRData
);
	localparam int addrW = $clog2(memWords);

	logic hostRd, dataRd, fetchRd;

	// Fixed priority host > data > fetch
	assign dataGrant = dataEn && !hostEn;
	assign fetchGrant = fetchEn && !hostEn && !dataEn;

	assign memEn = hostEn || dataEn || fetchEn;
	assign memWe = hostEn ? hostWe : (dataEn && dataWe);
	assign memWData = hostEn ? hostWData : dataWData;

	// Byte addresses from the core become word indices
	always_comb begin
		if (hostEn) begin
			memAddr = hostAddr;
		end else if (dataEn) begin
			memAddr = dataAddr[addrW+1:2];
		end else begin
			memAddr = fetchAddr[addrW+1:2];
		end
	end

	// Owner of the read in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			hostRd <= 1'b0;
			dataRd <= 1'b0;
			fetchRd <= 1'b0;
		end else begin
			hostRd <= hostEn && !hostWe;
			dataRd <= dataGrant && !dataWe;
			fetchRd <= fetchGrant;
		end
	end

	assign hostRData = hostRd ? memRData : '0;
	assign dataRData = dataRd ? memRData : '0;
	assign fetchData = fetchRd ? memRData : '0;
endmodule

//--- src/unifiedMem.sv
// Contents are not cleared by reset and a write leaves rData unchanged
`timescale 1ns/1ps

module unifiedMem import mipsPkg::*; #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic en,
	input logic we,
	input logic [$clog2(memWords)-1:0] addr,
	input wordT wData,
	output wordT rData
);
	wordT mem [memWords];

	// One access per cycle with registered read data
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wData;
			end else begin
				rData <= mem[addr];
			end
		end
	end
endmodule

//--- src/cpuPipeline.sv
// No delay slot and no traps while the PC simply wraps past the end of memory
`timescale 1ns/1ps

module cpuPipeline import mipsPkg::*; #(
	parameter wordT resetPc = '0
) (
	input logic clk,
	input logic reset,
	output logic fetchEn,
	output wordT fetchAddr,
	input wordT fetchData,
	input logic fetchGrant,
	output logic dataEn,
	output logic dataWe,
	output wordT dataAddr,
	output wordT dataWData,
	input wordT dataRData,
	input logic dataGrant,
	output logic halted
);
	wordT pc;
	logic stopFetch;
	logic ifIdValid, ifIdFresh;
	wordT ifIdPc, ifIdHold, idInst;
	logic idRegWr, idRegDst, idAluSrc, idExtOp, idMemWr, idMemToReg, idUseShamt, idIsHalt;
	aluCtrlT idAluCtrl;
	branchT idBranch;
	regIdxT idRs, idRt;
	wordT idRsVal, idRtVal, idImm;
	logic [4:0] idShamt;
	logic rsUsed, rtUsed;
	logic idExValid, idExRegWr, idExMemWr, idExMemToReg, idExHalt, idExAluSrc;
	branchT idExBranch;
	aluCtrlT idExAluCtrl;
	regIdxT idExRs, idExRt, idExDest;
	wordT idExPc, idExRsVal, idExRtVal, idExImm;
	logic [4:0] idExShamt;
	wordT fwdA, fwdB, aluB, aluResult, brTarget;
	logic aluZero, aluSign, brCond, taken;
	logic freeze, loadUse, idAdvance;
	logic exMemValid, exMemRegWr, exMemMemWr, exMemMemToReg, exMemHalt;
	regIdxT exMemDest;
	wordT exMemAlu, exMemStore;
	logic memWbValid, memWbRegWr, memWbMemToReg, memWbHalt;
	regIdxT memWbDest;
	wordT memWbAlu, wbData;
	logic wbWrEn;

	// Fresh word comes straight from memory, otherwise the held copy
	assign idInst = ifIdFresh ? fetchData : ifIdHold;
	assign idRs = idInst[25:21];
	assign idRt = idInst[20:16];
	assign idImm = idExtOp ? {{16{idInst[15]}}, idInst[15:0]} : {16'b0, idInst[15:0]};
	assign idShamt = idUseShamt ? idInst[10:6] : 5'd0;
	assign rsUsed = !idUseShamt;
	assign rtUsed = !idAluSrc || idMemWr;

	instDecoder decoder (
		.inst(idInst), .regWr(idRegWr), .regDst(idRegDst), .aluSrc(idAluSrc),
		.extOp(idExtOp), .memWr(idMemWr), .memToReg(idMemToReg), .useShamt(idUseShamt),
		.isHalt(idIsHalt), .aluCtrl(idAluCtrl), .branch(idBranch)
	);

	regFile regs (
		.clk(clk), .reset(reset), .wrEn(wbWrEn), .wrIdx(memWbDest), .wrData(wbData),
		.rdIdxA(idRs), .rdIdxB(idRt), .rdDataA(idRsVal), .rdDataB(idRtVal)
	);

	// Youngest producer wins
	function automatic wordT forward(input regIdxT idx, input wordT regVal);
		if (exMemValid && exMemRegWr && exMemDest != '0 && exMemDest == idx) begin
			return exMemAlu;
		end else if (wbWrEn && memWbDest != '0 && memWbDest == idx) begin
			return wbData;
		end
		return regVal;
	endfunction

	always_comb begin
		fwdA = forward(idExRs, idExRsVal);
		fwdB = forward(idExRt, idExRtVal);
	end

	assign aluB = idExAluSrc ? idExImm : fwdB;

	alu exAlu (
		.ctrl(idExAluCtrl), .a(fwdA), .b(aluB), .shamt(idExShamt),
		.result(aluResult), .zero(aluZero), .sign(aluSign)
	);

	always_comb begin
		case (idExBranch)
			brEq: brCond = aluZero;
			brNe: brCond = !aluZero;
			brGtz: brCond = !aluZero && !aluSign;
			default: brCond = 1'b0;
		endcase
	end

	assign taken = idExValid && brCond;
	assign brTarget = idExPc + 32'd4 + {idExImm[29:0], 2'b00};

	// Hazards
	assign freeze = dataEn && !dataGrant;
	assign loadUse = ifIdValid && idExValid && idExMemToReg && idExDest != '0 &&
		((rsUsed && idRs == idExDest) || (rtUsed && idRt == idExDest));
	assign idAdvance = !freeze && !loadUse;

	assign fetchEn = idAdvance && !taken && !stopFetch && !(ifIdValid && idIsHalt);
	assign fetchAddr = pc;

	assign dataEn = exMemValid && (exMemMemWr || exMemMemToReg);
	assign dataWe = exMemMemWr;
	assign dataAddr = exMemAlu;
	assign dataWData = exMemStore;

	// Load data arrives during WB
	assign wbData = memWbMemToReg ? dataRData : memWbAlu;
	assign wbWrEn = memWbValid && memWbRegWr;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			stopFetch <= 1'b0;
			ifIdValid <= 1'b0;
			ifIdFresh <= 1'b0;
			idExValid <= 1'b0;
			idExRegWr <= 1'b0;
			idExMemWr <= 1'b0;
			idExMemToReg <= 1'b0;
			idExHalt <= 1'b0;
			idExBranch <= brNone;
			exMemValid <= 1'b0;
			exMemRegWr <= 1'b0;
			exMemMemWr <= 1'b0;
			exMemMemToReg <= 1'b0;
			exMemHalt <= 1'b0;
			memWbValid <= 1'b0;
			memWbRegWr <= 1'b0;
			memWbMemToReg <= 1'b0;
			memWbHalt <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (!freeze && taken) begin
				pc <= brTarget;
			end else if (fetchEn && fetchGrant) begin
				pc <= pc + 32'd4;
			end
			// Halt past ID means nothing younger is needed
			if (idAdvance && !taken && ifIdValid && idIsHalt) begin
				stopFetch <= 1'b1;
			end
			ifIdFresh <= fetchEn && fetchGrant;
			if (!freeze && (taken || !loadUse)) begin
				ifIdValid <= fetchEn && fetchGrant;
			end
			if (!freeze) begin
				idExValid <= ifIdValid && !loadUse && !taken;
				idExRegWr <= idRegWr;
				idExMemWr <= idMemWr;
				idExMemToReg <= idMemToReg;
				idExHalt <= idIsHalt;
				idExBranch <= idBranch;
				exMemValid <= idExValid;
				exMemRegWr <= idExRegWr;
				exMemMemWr <= idExMemWr;
				exMemMemToReg <= idExMemToReg;
				exMemHalt <= idExHalt;
			end
			// A frozen MEM stage sends a bubble into WB
			memWbValid <= exMemValid && !freeze;
			memWbRegWr <= exMemRegWr;
			memWbMemToReg <= exMemMemToReg;
			memWbHalt <= exMemHalt;
			if (memWbValid && memWbHalt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		ifIdHold <= idInst;
		if (fetchEn && fetchGrant) begin
			ifIdPc <= pc;
		end
		if (!freeze) begin
			idExPc <= ifIdPc;
			idExRs <= idRs;
			idExRt <= idRt;
			idExRsVal <= idRsVal;
			idExRtVal <= idRtVal;
			idExImm <= idImm;
			idExShamt <= idShamt;
			idExDest <= idRegDst ? idInst[15:11] : idRt;
			idExAluCtrl <= idAluCtrl;
			idExAluSrc <= idAluSrc;
			exMemAlu <= aluResult;
			exMemStore <= fwdB;
			exMemDest <= idExDest;
		end else begin
			// Keep forwarded operands, the WB producer retires during the freeze
			idExRsVal <= fwdA;
			idExRtVal <= fwdB;
		end
		memWbAlu <= exMemAlu;
		memWbDest <= exMemDest;
	end
endmodule

//--- src/cpuTop.sv
// hostAddr is a word index while the core itself issues byte addresses
`timescale 1ns/1ps

module cpuTop import mipsPkg::*; #(
	parameter int memWords = 256,
	parameter wordT resetPc = '0
) (
	input logic clk,
	input logic reset,
	input logic hostEn,
	input logic hostWe,
	input logic [$clog2(memWords)-1:0] hostAddr,
	input wordT hostWData,
	output wordT hostRData,
	output logic halted
);
	localparam int addrW = $clog2(memWords);

	logic fetchEn, fetchGrant, dataEn, dataWe, dataGrant, memEn, memWe;
	wordT fetchAddr, fetchData, dataAddr, dataWData, dataRData, memWData, memRData;
	logic [addrW-1:0] memAddr;

	cpuPipeline #(.resetPc(resetPc)) core (
		.clk(clk), .reset(reset),
		.fetchEn(fetchEn), .fetchAddr(fetchAddr), .fetchData(fetchData),
		.fetchGrant(fetchGrant), .dataEn(dataEn), .dataWe(dataWe), .dataAddr(dataAddr),
		.dataWData(dataWData), .dataRData(dataRData), .dataGrant(dataGrant),
		.halted(halted)
	);

	memArbiter #(.memWords(memWords)) arbiter (
		.clk(clk), .reset(reset),
		.hostEn(hostEn), .hostWe(hostWe), .hostAddr(hostAddr), .hostWData(hostWData),
		.hostRData(hostRData), .fetchEn(fetchEn), .fetchAddr(fetchAddr),
		.fetchData(fetchData), .fetchGrant(fetchGrant), .dataEn(dataEn), .dataWe(dataWe),
		.dataAddr(dataAddr), .dataWData(dataWData), .dataRData(dataRData),
		.dataGrant(dataGrant), .memEn(memEn), .memWe(memWe), .memAddr(memAddr),
		.memWData(memWData), .memRData(memRData)
	);

	unifiedMem #(.memWords(memWords)) mem (
		.clk(clk), .en(memEn), .we(memWe), .addr(memAddr), .wData(memWData),
		.rData(memRData)
	);
endmodule

//--- dv/cpuTb.sv
// Run from the project root so dv/cpuTests.txt is found and keep programs below word 64
`timescale 1ns/1ps

module cpuTb;
	localparam int memWords = 256;
	localparam int addrW = $clog2(memWords);
	localparam int resultBase = 64;
	localparam int resultWords = 16;
	localparam int haltTimeout = 2000;
	localparam int resetCycles = 10;

	logic clk;
	logic reset;
	logic hostEn;
	logic hostWe;
	logic [addrW-1:0] hostAddr;
	logic [31:0] hostWData;
	logic [31:0] hostRData;
	logic halted;

	// Current test as filled by the file parser
	logic [31:0] prog[$];
	int expAddr[$];
	logic [31:0] expData[$];

	cpuTop #(.memWords(memWords), .resetPc(32'd0)) dut (
		.clk(clk), .reset(reset), .hostEn(hostEn), .hostWe(hostWe), .hostAddr(hostAddr),
		.hostWData(hostWData), .hostRData(hostRData), .halted(halted)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string testName, input int addr, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stopOnFailure($sformatf("mismatch %s word %0h expected %08h actual %08h",
				testName, addr, expected, actual));
		end
	endtask

	// Write lands on the next rising edge
	task automatic hostWrite(input int addr, input logic [31:0] data);
		@(negedge clk);
		hostEn = 1'b1;
		hostWe = 1'b1;
		hostAddr = addr[addrW-1:0];
		hostWData = data;
	endtask

	// Read data is valid one cycle after the request
	task automatic hostRead(input int addr, output logic [31:0] data);
		@(negedge clk);
		hostEn = 1'b1;
		hostWe = 1'b0;
		hostAddr = addr[addrW-1:0];
		@(negedge clk);
		data = hostRData;
		hostEn = 1'b0;
	endtask

	task automatic runTest(input string name);
		int cycles;
		int waited;
		logic [31:0] readBack;
		@(negedge clk);
		reset = 1'b1;
		cycles = 0;
		foreach (prog[i]) begin
			hostWrite(i, prog[i]);
			cycles++;
		end
		for (int i = 0; i < resultWords; i++) begin
			hostWrite(resultBase + i, 32'd0);
			cycles++;
		end
		@(negedge clk);
		hostEn = 1'b0;
		hostWe = 1'b0;
		cycles++;
		// Reset stays high for the minimum or longer when loading takes more cycles
		while (cycles < resetCycles) begin
			@(negedge clk);
			cycles++;
		end
		reset = 1'b0;
		waited = 0;
		while (!halted) begin
			if (waited >= haltTimeout) begin
				stopOnFailure($sformatf("program %s did not halt within %0d cycles",
					name, haltTimeout));
			end
			@(negedge clk);
			waited++;
		end
		foreach (expAddr[i]) begin
			hostRead(expAddr[i], readBack);
			checkWord(name, expAddr[i], expData[i], readBack);
		end
	endtask

	initial begin
		int fd;
		int testCount;
		int count;
		int c;
		int addr;
		logic [31:0] word;
		string tok;
		string name;
		reset = 1'b1;
		hostEn = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWData = 32'd0;
		testCount = 0;
		fd = $fopen("dv/cpuTests.txt", "r");
		if (fd == 0) begin
			stopOnFailure("cannot open dv/cpuTests.txt");
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok[0] == "#") begin
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (tok == "test") begin
				if ($fscanf(fd, "%s %d", name, count) != 2 || count > resultBase) begin
					stopOnFailure("bad test header or program too long in test file");
				end
				prog.delete();
				expAddr.delete();
				expData.delete();
				for (int i = 0; i < count; i++) begin
					if ($fscanf(fd, "%h", word) != 1) begin
						stopOnFailure($sformatf("missing program word in test %s", name));
					end
					prog.push_back(word);
				end
				if ($fscanf(fd, "%d", count) != 1) begin
					stopOnFailure($sformatf("missing expected count in test %s", name));
				end
				for (int i = 0; i < count; i++) begin
					if ($fscanf(fd, "%h %h", addr, word) != 2 || addr >= memWords) begin
						stopOnFailure($sformatf("bad expected pair in test %s", name));
					end
					expAddr.push_back(addr);
					expData.push_back(word);
				end
				$display("running %s", name);
				runTest(name);
				testCount++;
			end else begin
				stopOnFailure($sformatf("unexpected token %s in test file", tok));
			end
		end
		$fclose(fd);
		if (testCount == 0) begin
			stopOnFailure("no tests were found in the test file");
		end else begin
			$display("test passed");
			$finish;
		end
	end
endmodule

//--- dv/cpuTests.txt
# test <name> <program word count, decimal> <program words, hex>
# then <expected count, decimal> and pairs of <word address, hex> <data, hex>
test arith 25
20010007 2002FFFD 00221820 00222022 00222824 00223025 0041382A 0041402B
00014900 00415023 00C15821 0022602B 202DFFF8 AC030100 AC040104 AC050108
AC06010C AC070110 AC080114 AC090118 AC0A011C AC0B0120 AC0C0124 AC0D0128
FC000000
11 40 4 41 A 42 5 43 FFFFFFFF 44 1 45 0 46 70 47 FFFFFFF6 48 6 49 1 4A FFFFFFFF
test forward 14
20010005 00211020 00411822 00622025 00042880 AC050100 20060003 20070004
00C74020 AC020104 AC030108 AC04010C AC080110 FC000000
5 40 3C 41 A 42 5 43 F 44 7
test loaduse 16
20010055 AC010180 2002000F 8C030180 00632020 AC040100 8C050180 AC050104
8C060100 00C23822 AC070108 8C080104 00000000 21090001 AC09010C FC000000
4 40 AA 41 55 42 9B 43 56
test branch 25
20010005 20020005 2003FFFE 200A0001 10220001 AC0A0100 14220001 AC0A0104
1C600001 AC0A0108 1C000001 AC0A010C 1C200002 AC0A0110 AC0A0114 14230001
AC0A0118 10230001 AC0A011C 20050003 20C60002 20A5FFFF 1CA0FFFD AC060120
FC000000
9 40 0 41 1 42 1 43 1 44 0 45 0 46 0 47 1 48 6
test restart 7
20430001 AC03010C 20010077 AC010100 FC000000 AC010104 AC010108
4 43 1 40 77 41 0 42 0

//--- filelist.f
src/mipsPkg.sv
src/instDecoder.sv
src/regFile.sv
src/alu.sv
src/memArbiter.sv
src/unifiedMem.sv
src/cpuPipeline.sv
src/cpuTop.sv
dv/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs from the project root so the testbench finds dv/cpuTests.txt
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timescale 1ns/1ps --top-module cpuTb -f filelist.f -o cpuSim
./obj_dir/cpuSim | tee sim.log
if grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished, see sim.log"
